//--- hw/stageOnePkg.sv
package stageOnePkg;

	////////////////////////////////////////////////////////////
	// Instruction fields

	typedef enum logic [4:0] {
		OP_ADD    = 5'b00000,
		OP_SUB    = 5'b00001,
		OP_OR     = 5'b00011,
		OP_AND    = 5'b00100,
		OP_SHFT   = 5'b00101,
		OP_LOAD   = 5'b01010,
		OP_STOR   = 5'b01011,
		OP_INPUT  = 5'b01100,
		OP_OUTPUT = 5'b01101,
		OP_NOP    = 5'b01111
	} opcodeE;

	typedef enum logic [2:0] {
		MODE_DIR = 3'b000,
		MODE_IND = 3'b001,
		MODE_IMM = 3'b010
	} addrModeE; // Shift kind for SHFT

	typedef enum logic [1:0] {
		SH_LS0 = 2'd0, // Left, fill 0
		SH_LS1 = 2'd1,
		SH_RS0 = 2'd2,
		SH_RS1 = 2'd3
	} shiftKindE;

	typedef struct packed {
		opcodeE      opcode;
		addrModeE    mode;
		logic [7:0]  operand;
	} instrPacketT;

	////////////////////////////////////////////////////////////
	// Decode and sequencing

	typedef enum logic [3:0] {
		SEQ_ALU_DIR, SEQ_ALU_IND, SEQ_ALU_IMM, SEQ_STOR_DIR, SEQ_STOR_IND,
		SEQ_SHIFT, SEQ_INPUT, SEQ_OUTPUT, SEQ_NOP, SEQ_ILLEGAL
	} seqKindE;

	typedef struct packed {
		seqKindE     kind;
		instrPacketT packet;
	} decodedT;

	typedef enum logic [2:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_OR, ALU_AND
	} aluOpE;

	typedef enum logic [3:0] {
		STEP_IDLE, STEP_PTR_READ, STEP_OPND_READ, STEP_EXEC, STEP_STORE,
		STEP_SHIFT_STEP, STEP_IO_WAIT
	} microStepE;

	////////////////////////////////////////////////////////////
	// Control word to the datapath

	localparam int SHIFT_COUNT_W = 3;

	typedef struct packed {
		aluOpE                    aluOp;
		logic                     immSel;   // Operand from instruction
		logic                     addrSel;  // 1 selects MDR as address
		logic                     memRead;
		logic                     memWrite;
		logic                     accLoad;
		logic                     shiftEn;
		shiftKindE                shiftKind;
		logic [SHIFT_COUNT_W-1:0] shiftCount;
		logic                     ioIn;
		logic                     ioOut;
	} ctrlWordT;

	localparam ctrlWordT CTRL_IDLE = '0;

endpackage

//--- hw/instrIntake.sv
`timescale 1ns/100ps
module instrIntake (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     instrReq,
	input  stageOnePkg::instrPacketT instr,
	output logic                     instrAck,
	output stageOnePkg::decodedT     decoded,
	output logic                     decValid,
	input  logic                     take
);
	import stageOnePkg::*;

	instrPacketT held;
	logic        accept;

	function automatic seqKindE classify(input instrPacketT p);
		case (p.opcode)
			OP_ADD, OP_SUB, OP_OR, OP_AND, OP_LOAD: begin
				case (p.mode)
					MODE_DIR: return SEQ_ALU_DIR;
					MODE_IND: return SEQ_ALU_IND;
					MODE_IMM: return SEQ_ALU_IMM;
					default:  return SEQ_ILLEGAL;
				endcase
			end
			OP_STOR: begin
				case (p.mode)
					MODE_DIR: return SEQ_STOR_DIR;
					MODE_IND: return SEQ_STOR_IND;
					default:  return SEQ_ILLEGAL; // No immediate store
				endcase
			end
			OP_SHFT:   return (p.mode <= 3'd3) ? SEQ_SHIFT : SEQ_ILLEGAL;
			OP_INPUT:  return SEQ_INPUT;
			OP_OUTPUT: return SEQ_OUTPUT;
			OP_NOP:    return SEQ_NOP;
			default:   return SEQ_ILLEGAL;
		endcase
	endfunction

	assign accept = instrReq && !instrAck && !decValid; // Buffer free, new request

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrAck <= 1'b0;
			decValid <= 1'b0;
		end else begin
			if (accept)
				instrAck <= 1'b1;
			else if (!instrReq)
				instrAck <= 1'b0; // Phase 4
			if (accept)
				decValid <= 1'b1;
			else if (take)
				decValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			held <= instr;
	end

	always_comb begin
		decoded.kind   = classify(held);
		decoded.packet = held;
	end

	assert property (@(posedge clk) disable iff (!rstN) $rose(instrAck) |-> !$past(decValid));

endmodule

//--- hw/microSequencer.sv
`timescale 1ns/100ps
module microSequencer (
	input  logic                     clk,
	input  logic                     rstN,
	input  stageOnePkg::decodedT     decoded,
	input  logic                     decValid,
	output logic                     take,
	output stageOnePkg::microStepE   step,
	output stageOnePkg::instrPacketT packet,
	output stageOnePkg::seqKindE     kind,
	output logic                     ctrlValid,
	output logic                     ioStart,
	output logic                     ioDir,
	input  logic                     ioStep,
	input  logic                     ioDone
);
	import stageOnePkg::*;

	microStepE firstStep;
	microStepE nextStep;

	assign take = (step == STEP_IDLE) && decValid;

	////////////////////////////////////////////////////////////
	// Entry step per sequence kind

	always_comb begin
		case (decoded.kind)
			SEQ_ALU_DIR:              firstStep = STEP_OPND_READ;
			SEQ_ALU_IND, SEQ_STOR_IND: firstStep = STEP_PTR_READ;
			SEQ_ALU_IMM:              firstStep = STEP_EXEC;
			SEQ_STOR_DIR:             firstStep = STEP_STORE;
			SEQ_SHIFT:                firstStep = STEP_SHIFT_STEP;
			SEQ_INPUT, SEQ_OUTPUT:    firstStep = STEP_IO_WAIT;
			default:                  firstStep = STEP_IDLE; // NOP, illegal
		endcase
	end

	////////////////////////////////////////////////////////////
	// Step transitions

	always_comb begin
		nextStep = step;
		case (step)
			STEP_IDLE: begin
				if (take)
					nextStep = firstStep;
			end
			STEP_PTR_READ: begin
				if (kind == SEQ_STOR_IND)
					nextStep = STEP_STORE;
				else
					nextStep = STEP_OPND_READ;
			end
			STEP_OPND_READ: nextStep = STEP_EXEC;
			STEP_IO_WAIT: begin
				if (ioDone)
					nextStep = STEP_IDLE; // Device handshake finished
			end
			default: nextStep = STEP_IDLE; // Last step of a sequence
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			step    <= STEP_IDLE;
			kind    <= SEQ_NOP;
			ioStart <= 1'b0;
		end else begin
			step    <= nextStep;
			ioStart <= take && (firstStep == STEP_IO_WAIT);
			if (take)
				kind <= decoded.kind;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			packet <= decoded.packet;
	end

	assign ioDir = (kind == SEQ_OUTPUT);

	// IO_WAIT only counts its data phase
	always_comb begin
		if (step == STEP_IO_WAIT)
			ctrlValid = ioStep;
		else
			ctrlValid = (step != STEP_IDLE);
	end

	assert property (@(posedge clk) disable iff (!rstN)
		(step == STEP_IO_WAIT && !ioDone) |=> (step == STEP_IO_WAIT));

endmodule

//--- hw/controlWordRom.sv
`timescale 1ns/100ps
module controlWordRom (
	input  stageOnePkg::microStepE   step,
	input  stageOnePkg::seqKindE     kind,
	input  stageOnePkg::instrPacketT packet,
	input  logic                     ioStep,
	output stageOnePkg::ctrlWordT    ctrl
);
	import stageOnePkg::*;

	aluOpE execOp;

	always_comb begin
		case (packet.opcode)
			OP_ADD:  execOp = ALU_ADD;
			OP_SUB:  execOp = ALU_SUB;
			OP_OR:   execOp = ALU_OR;
			OP_AND:  execOp = ALU_AND;
			default: execOp = ALU_PASS; // LOAD
		endcase
	end

	always_comb begin
		ctrl = CTRL_IDLE;
		case (step)
			STEP_PTR_READ: ctrl.memRead = 1'b1; // Fetch pointer at operand
			STEP_OPND_READ: begin
				ctrl.memRead = 1'b1;
				ctrl.addrSel = (kind == SEQ_ALU_IND);
			end
			STEP_EXEC: begin
				ctrl.accLoad = 1'b1;
				ctrl.aluOp   = execOp;
				ctrl.immSel  = (kind == SEQ_ALU_IMM);
			end
			STEP_STORE: begin
				ctrl.memWrite = 1'b1;
				ctrl.addrSel  = (kind == SEQ_STOR_IND);
			end
			STEP_SHIFT_STEP: begin
				ctrl.shiftEn    = 1'b1;
				ctrl.shiftKind  = shiftKindE'(packet.mode[1:0]);
				ctrl.shiftCount = packet.operand[SHIFT_COUNT_W-1:0];
			end
			STEP_IO_WAIT: begin
				if (ioStep) begin
					ctrl.ioIn    = (kind == SEQ_INPUT);
					ctrl.accLoad = (kind == SEQ_INPUT); // Device data into ACC
					ctrl.ioOut   = (kind == SEQ_OUTPUT);
				end
			end
			default: ctrl = CTRL_IDLE;
		endcase
	end

	always_comb begin
		assert (!(ctrl.memRead && ctrl.memWrite));
	end

endmodule

//--- hw/deviceHandshake.sv
`timescale 1ns/100ps
module deviceHandshake (
	input  logic clk,
	input  logic rstN,
	input  logic ioStart,
	input  logic ioDir,
	output logic ioStep,
	output logic ioDone,
	input  logic inReq,
	output logic inAck,
	output logic outReq,
	input  logic outAck
);

	typedef enum logic [2:0] {
		HS_IDLE, IN_WAIT_REQ, IN_WAIT_DROP, OUT_WAIT_ACK, OUT_WAIT_DROP
	} hsStateE;

	hsStateE state;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state  <= HS_IDLE;
			inAck  <= 1'b0;
			outReq <= 1'b0;
			ioStep <= 1'b0;
			ioDone <= 1'b0;
		end else begin
			ioStep <= 1'b0;
			ioDone <= 1'b0;
			case (state)
				HS_IDLE: begin
					if (ioStart && ioDir) begin
						outReq <= 1'b1;
						state  <= OUT_WAIT_ACK;
					end else if (ioStart) begin
						state <= IN_WAIT_REQ;
					end
				end
				IN_WAIT_REQ: begin
					if (inReq) begin
						inAck  <= 1'b1;
						ioStep <= 1'b1; // Data phase
						state  <= IN_WAIT_DROP;
					end
				end
				IN_WAIT_DROP: begin
					if (!inReq) begin
						inAck  <= 1'b0;
						ioDone <= 1'b1;
						state  <= HS_IDLE;
					end
				end
				OUT_WAIT_ACK: begin
					if (outAck) begin
						outReq <= 1'b0;
						ioStep <= 1'b1;
						state  <= OUT_WAIT_DROP;
					end
				end
				OUT_WAIT_DROP: begin
					if (!outAck) begin
						ioDone <= 1'b1;
						state  <= HS_IDLE;
					end
				end
				default: state <= HS_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) $fell(outReq) |-> $past(outAck));

endmodule

//--- hw/stageOneCtrl.sv
`timescale 1ns/100ps
module stageOneCtrl (
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     instrReq,
	input  stageOnePkg::instrPacketT instr,
	output logic                     instrAck,
	output stageOnePkg::ctrlWordT    ctrl,
	output logic                     ctrlValid,
	input  logic                     inReq,
	output logic                     inAck,
	output logic                     outReq,
	input  logic                     outAck
);
	import stageOnePkg::*;

	decodedT     decoded;
	logic        decValid;
	logic        take;
	microStepE   step;
	instrPacketT packet;
	seqKindE     kind;
	logic        ioStart;
	logic        ioDir;
	logic        ioStep;
	logic        ioDone;

	////////////////////////////////////////////////////////////
	// Intake, sequencer, control table, device port

	instrIntake uIntake (
		.clk, .rstN, .instrReq, .instr, .instrAck,
		.decoded, .decValid, .take
	);

	microSequencer uSequencer (
		.clk, .rstN, .decoded, .decValid, .take, .step, .packet, .kind,
		.ctrlValid, .ioStart, .ioDir, .ioStep, .ioDone
	);

	controlWordRom uRom (
		.step, .kind, .packet, .ioStep, .ctrl
	);

	deviceHandshake uHandshake (
		.clk, .rstN, .ioStart, .ioDir, .ioStep, .ioDone,
		.inReq, .inAck, .outReq, .outAck
	);

endmodule

//--- test/tbClock.sv
`timescale 1ns/100ps
module tbClock (
	output logic clk,
	output logic rstN
);

	initial begin
		clk  = 1'b0;
		rstN = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1; // Released on a falling edge
	end

	always #10 clk = ~clk; // 20 ns period

endmodule

//--- test/stageOneModel.svh
`ifndef STAGE_ONE_MODEL_SVH
`define STAGE_ONE_MODEL_SVH

// Expected control words in issue order
ctrlWordT expQ[$];
int       expTotal = 0;

function automatic aluOpE expectedAluOp(input opcodeE op);
	case (op)
		OP_ADD:  return ALU_ADD;
		OP_SUB:  return ALU_SUB;
		OP_OR:   return ALU_OR;
		OP_AND:  return ALU_AND;
		default: return ALU_PASS; // LOAD passes the operand
	endcase
endfunction

function automatic shiftKindE expectedShiftKind(input addrModeE m);
	case (m)
		3'd0:    return SH_LS0;
		3'd1:    return SH_LS1;
		3'd2:    return SH_RS0;
		default: return SH_RS1;
	endcase
endfunction

function automatic ctrlWordT memAccess(input logic rd, input logic wr, input logic fromMdr);
	ctrlWordT w;
	w          = CTRL_IDLE;
	w.memRead  = rd;
	w.memWrite = wr;
	w.addrSel  = fromMdr;
	return w;
endfunction

task automatic pushStep(input ctrlWordT w);
	expQ.push_back(w);
	expTotal++;
endtask

task automatic predictSteps(input instrPacketT p);
	ctrlWordT w;
	logic     aluLike;
	aluLike = p.opcode inside {OP_ADD, OP_SUB, OP_OR, OP_AND, OP_LOAD};
	w = CTRL_IDLE;
	if (aluLike && p.mode <= MODE_IMM) begin
		if (p.mode == MODE_IND)
			pushStep(memAccess(1'b1, 1'b0, 1'b0)); // Pointer fetch
		if (p.mode != MODE_IMM)
			pushStep(memAccess(1'b1, 1'b0, p.mode == MODE_IND));
		w.accLoad = 1'b1;
		w.aluOp   = expectedAluOp(p.opcode);
		w.immSel  = (p.mode == MODE_IMM);
		pushStep(w);
	end else if (p.opcode == OP_STOR && p.mode <= MODE_IND) begin
		if (p.mode == MODE_IND)
			pushStep(memAccess(1'b1, 1'b0, 1'b0));
		pushStep(memAccess(1'b0, 1'b1, p.mode == MODE_IND));
	end else if (p.opcode == OP_SHFT && p.mode <= 3'd3) begin
		w.shiftEn    = 1'b1;
		w.shiftKind  = expectedShiftKind(p.mode);
		w.shiftCount = p.operand[SHIFT_COUNT_W-1:0]; // Low operand bits
		pushStep(w);
	end else if (p.opcode == OP_INPUT) begin
		w.ioIn    = 1'b1;
		w.accLoad = 1'b1;
		pushStep(w);
	end else if (p.opcode == OP_OUTPUT) begin
		w.ioOut = 1'b1;
		pushStep(w);
	end
	// NOP and undefined codes give no micro-step
endtask

`endif

//--- test/tbStageOne.sv
`timescale 1ns/100ps
module tbStageOne;
	import stageOnePkg::*;

	localparam int NUM_INSTR    = 300;
	localparam int CLK_PERIOD   = 20;
	localparam int SEED         = 30664;
	localparam int DRAIN_CYCLES = 100;

	typedef struct packed {
		logic instrReq;
		logic instrAck;
		logic inReq;
		logic inAck;
		logic outReq;
		logic outAck;
	} hsLevelsT;

	logic        clk;
	logic        rstN;
	logic        instrReq;
	instrPacketT instr;
	logic        instrAck;
	ctrlWordT    ctrl;
	logic        ctrlValid;
	logic        inReq;
	logic        inAck;
	logic        outReq;
	logic        outAck;
	hsLevelsT    nowLevels;
	hsLevelsT    prevLevels = '0;
	int          seed = SEED;
	int          inSeed = SEED + 1; // Separate streams per device
	int          outSeed = SEED + 2;
	int          gotCount = 0;

	`include "stageOneModel.svh"

	tbClock uClock (.clk, .rstN);

	stageOneCtrl u_dut (.*);

	assign nowLevels = {instrReq, instrAck, inReq, inAck, outReq, outAck};

	////////////////////////////////////////////////////////////
	// Compare and failure tasks

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic checkCtrl(input ctrlWordT got, input ctrlWordT exp);
		if (got !== exp)
			abortRun($sformatf("** Error: ctrl = 0x%h, expected 0x%h", got, exp));
	endtask

	task automatic checkStepCount(input int got, input int exp, output bit ok);
		ok = (got == exp);
		if (!ok)
			$display("** Error: micro-step count = 0x%h, expected 0x%h", got, exp);
	endtask

	task automatic expectLow(input string name, input logic level);
		if (level !== 1'b0)
			abortRun($sformatf("** Error: %s = 0x%h, expected 0x0", name, level));
	endtask

	task automatic watchFourPhase(input hsLevelsT p, input hsLevelsT c);
		if (c.instrAck && !p.instrAck && !p.instrReq)
			abortRun("instrAck rose with no instrReq pending");
		else if (c.inAck && !p.inAck && !p.inReq)
			abortRun("inAck rose with no inReq from the input device");
		else if (!c.inAck && p.inAck && p.inReq)
			abortRun("inAck fell while inReq was still high");
		else if (!c.outReq && p.outReq && !p.outAck)
			abortRun("outReq fell before outAck was seen high");
		else if (c.outReq && !p.outReq && p.outAck)
			abortRun("outReq rose while outAck was still high");
	endtask

	////////////////////////////////////////////////////////////
	// Stage 0 driver

	function automatic instrPacketT randomPacket();
		instrPacketT p;
		case ($unsigned($random(seed)) % 12)
			0:       p.opcode = OP_ADD;
			1:       p.opcode = OP_SUB;
			2:       p.opcode = OP_OR;
			3:       p.opcode = OP_AND;
			4:       p.opcode = OP_SHFT;
			5:       p.opcode = OP_LOAD;
			6:       p.opcode = OP_STOR;
			7:       p.opcode = OP_INPUT;
			8:       p.opcode = OP_OUTPUT;
			9:       p.opcode = OP_NOP;
			default: p.opcode = opcodeE'(5'($random(seed))); // Mostly undefined
		endcase
		if ($random(seed) & 1)
			p.mode = addrModeE'(3'($random(seed)));
		else
			p.mode = addrModeE'(3'($random(seed) & 3));
		p.operand = 8'($random(seed));
		return p;
	endfunction

	task automatic sendInstr(input instrPacketT p);
		predictSteps(p);
		instr    = p;
		instrReq = 1'b1;
		do @(negedge clk); while (!instrAck);
		instrReq = 1'b0;
		do @(negedge clk); while (instrAck);
	endtask

	initial begin : stimulus
		bit countOk;
		instrReq = 1'b0;
		instr    = '0;
		@(posedge rstN);
		@(negedge clk);
		expectLow("instrAck", instrAck);
		expectLow("ctrlValid", ctrlValid);
		expectLow("inAck", inAck);
		expectLow("outReq", outReq);
		checkCtrl(ctrl, CTRL_IDLE);
		for (int i = 0; i < NUM_INSTR; i++) begin
			sendInstr(randomPacket());
			repeat ($unsigned($random(seed)) % 3) @(negedge clk);
		end
		for (int n = 0; n < DRAIN_CYCLES && gotCount < expTotal; n++)
			@(negedge clk); // Last steps may still be in flight
		repeat (20) @(negedge clk); // Catches stray micro-steps
		checkStepCount(gotCount, expTotal, countOk);
		if (!countOk) begin
			abortRun("micro-step count differs from the model");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Device responders, collector, watchdog

	initial begin : inputDevice
		inReq = 1'b0;
		@(posedge rstN);
		forever begin
			repeat ($unsigned($random(inSeed)) % 6) @(negedge clk);
			@(negedge clk);
			inReq = 1'b1;
			do @(negedge clk); while (!inAck);
			repeat ($unsigned($random(inSeed)) % 6) @(negedge clk);
			inReq = 1'b0;
			do @(negedge clk); while (inAck);
		end
	end

	initial begin : outputDevice
		outAck = 1'b0;
		@(posedge rstN);
		forever begin
			do @(negedge clk); while (!outReq);
			repeat ($unsigned($random(outSeed)) % 6) @(negedge clk);
			outAck = 1'b1;
			do @(negedge clk); while (outReq);
			repeat ($unsigned($random(outSeed)) % 6) @(negedge clk);
			outAck = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rstN) begin
			if (!ctrlValid) begin
				checkCtrl(ctrl, CTRL_IDLE);
			end else if (expQ.size() == 0) begin
				abortRun("micro-step issued with none left in the model");
			end else begin
				checkCtrl(ctrl, expQ.pop_front());
				gotCount++;
			end
			watchFourPhase(prevLevels, nowLevels);
			prevLevels = nowLevels;
		end
	end

	initial begin : watchdog
		#(NUM_INSTR * 40 * CLK_PERIOD);
		abortRun("watchdog expired before all instructions finished");
	end

endmodule

//--- tb.f
+incdir+test
hw/stageOnePkg.sv
hw/instrIntake.sv
hw/microSequencer.sv
hw/controlWordRom.sv
hw/deviceHandshake.sv
hw/stageOneCtrl.sv
test/tbClock.sv
test/tbStageOne.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbStageOne
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_STR = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
